// ==== verilog/mchan_prog_pkg.sv ====
package mchan_prog_pkg;

   localparam int DATA_W     = 32;
   localparam int HALF_W     = 16;
   localparam int BE_W       = 4;
   localparam int NUM_PARAMS = 8;
   localparam int CNT_W      = 16;

   // opcode field of a programming write
   localparam int         OPC_LSB    = 16;
   localparam logic [3:0] OPC_PROG_A = 4'd6;
   localparam logic [3:0] OPC_PROG_B = 4'd7;

   // one captured word used whole or as two halves
   typedef union packed {
      logic [DATA_W-1:0] word;
      struct packed {
         logic [HALF_W-1:0] hi;
         logic [HALF_W-1:0] lo;
      } half;
   } param_word_u;

   typedef struct packed {
      logic              req;
      logic              wen;
      logic [BE_W-1:0]   be;
      logic [DATA_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } bus_req_t;

   typedef struct packed {
      logic              gnt;
      logic              r_valid;
      logic [DATA_W-1:0] rdata;
   } bus_rsp_t;

   typedef struct packed {
      logic [DATA_W-1:0] cmd_addr;
      logic [HALF_W-1:0] cmd_hi;
      logic [HALF_W-1:0] max_size;
      logic [HALF_W-1:0] last_size;
      logic [DATA_W-1:0] tcdm_base;
      logic [DATA_W-1:0] ext_base;
      logic [DATA_W-1:0] ext_stride;
      logic [DATA_W-1:0] tcdm_stride;
      logic [HALF_W-1:0] slot_step;
      logic [CNT_W-1:0]  tr_per_batch;
      logic [CNT_W-1:0]  num_batches;
      logic [DATA_W-1:0] batch_step;
   } prog_params_t;

   typedef enum logic [2:0] {
      IDLE,
      PASS,
      WAIT_VALID,
      CAPTURE,
      RUN
   } mode_e;

endpackage

// ==== verilog/prog_req_decode.sv ====
module prog_req_decode (
   input  logic                     clk_i,
   input  logic                     rst_ni,
   input  mchan_prog_pkg::bus_req_t core_req_i,
   input  mchan_prog_pkg::bus_rsp_t mchan_rsp_i,
   input  logic                     done_i,
   output mchan_prog_pkg::mode_e    mode_o,
   output logic [2:0]               cap_idx_o,
   output logic                     start_o
);

   mchan_prog_pkg::mode_e mode_q;
   logic [3:0]            cnt_q;
   logic                  gnt_ph_q;
   logic                  rsp_ph_q;
   logic                  start_q;
   logic                  opc_hit;
   logic                  is_prog;

   assign opc_hit = core_req_i.wdata[mchan_prog_pkg::OPC_LSB +: 4] == mchan_prog_pkg::OPC_PROG_A
                 || core_req_i.wdata[mchan_prog_pkg::OPC_LSB +: 4] == mchan_prog_pkg::OPC_PROG_B;
   // full-word write carrying a program opcode
   assign is_prog = core_req_i.req && !core_req_i.wen && (&core_req_i.be) && opc_hit;

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         mode_q   <= mchan_prog_pkg::IDLE;
         cnt_q    <= '0;
         gnt_ph_q <= 1'b0;
         rsp_ph_q <= 1'b0;
         start_q  <= 1'b0;
      end else begin
         start_q  <= 1'b0;
         gnt_ph_q <= 1'b0;
         rsp_ph_q <= 1'b0;
         case (mode_q)
            mchan_prog_pkg::IDLE: begin
               if (is_prog) begin
                  mode_q   <= mchan_prog_pkg::CAPTURE;
                  gnt_ph_q <= 1'b1;
                  cnt_q    <= '0;
               end else if (core_req_i.req) begin
                  mode_q <= mchan_prog_pkg::PASS;
               end
            end
            mchan_prog_pkg::PASS: begin
               if (mchan_rsp_i.gnt) begin
                  mode_q <= mchan_prog_pkg::WAIT_VALID;
               end
            end
            mchan_prog_pkg::WAIT_VALID: begin
               if (mchan_rsp_i.r_valid) begin
                  mode_q <= mchan_prog_pkg::IDLE;
               end
            end
            mchan_prog_pkg::CAPTURE: begin
               // tracks the grant and response slots issued by the mux
               rsp_ph_q <= gnt_ph_q;
               if (gnt_ph_q) begin
                  cnt_q <= cnt_q + 4'd1;
               end
               if (rsp_ph_q && cnt_q == 4'(mchan_prog_pkg::NUM_PARAMS)) begin
                  mode_q  <= mchan_prog_pkg::RUN;
                  start_q <= 1'b1;
               end else begin
                  gnt_ph_q <= core_req_i.req && !gnt_ph_q;
               end
            end
            mchan_prog_pkg::RUN: begin
               if (done_i) begin
                  mode_q <= mchan_prog_pkg::IDLE;
               end
            end
            default: mode_q <= mchan_prog_pkg::IDLE;
         endcase
      end
   end

   assign mode_o    = mode_q;
   assign cap_idx_o = cnt_q[2:0];
   assign start_o   = start_q;

endmodule

// ==== verilog/prog_param_store.sv ====
module prog_param_store (
   input  logic                         clk_i,
   input  logic                         rst_ni,
   input  mchan_prog_pkg::mode_e        mode_i,
   input  logic [2:0]                   cap_idx_i,
   input  mchan_prog_pkg::bus_req_t     core_req_i,
   output mchan_prog_pkg::prog_params_t params_o
);

   mchan_prog_pkg::param_word_u             regs_q [mchan_prog_pkg::NUM_PARAMS];
   logic [mchan_prog_pkg::DATA_W-1:0]       cmd_addr_q;
   logic                                    wr_en;

   // core holds the word until its grant, so the index is stable here
   assign wr_en = mode_i == mchan_prog_pkg::CAPTURE && core_req_i.req;

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         for (int i = 0; i < mchan_prog_pkg::NUM_PARAMS; i++) begin
            regs_q[i] <= '0;
         end
         cmd_addr_q <= '0;
      end else if (wr_en) begin
         regs_q[cap_idx_i].word <= core_req_i.wdata;
         if (cap_idx_i == 3'd0) begin
            cmd_addr_q <= core_req_i.addr;
         end
      end
   end

   always_comb begin
      params_o              = '0;
      params_o.cmd_addr     = cmd_addr_q;
      // word 0 packs the command half and the regular size
      params_o.cmd_hi       = regs_q[0].half.hi;
      params_o.max_size     = regs_q[0].half.lo;
      params_o.tcdm_base    = regs_q[1].word;
      params_o.ext_base     = regs_q[2].word;
      params_o.ext_stride   = regs_q[3].word;
      params_o.tcdm_stride  = regs_q[4].word;
      params_o.tr_per_batch = regs_q[5].half.hi;
      params_o.slot_step    = regs_q[5].half.lo;
      params_o.num_batches  = regs_q[6].half.hi;
      params_o.last_size    = regs_q[6].half.lo;
      params_o.batch_step   = regs_q[7].word;
   end

endmodule

// ==== verilog/prog_cmd_sequencer.sv ====
module prog_cmd_sequencer (
   input  logic                         clk_i,
   input  logic                         rst_ni,
   input  logic                         start_i,
   input  mchan_prog_pkg::prog_params_t params_i,
   input  logic                         mchan_gnt_i,
   output mchan_prog_pkg::bus_req_t     seq_req_o,
   output logic                         done_o
);

   logic                               busy_q;
   logic                               gap_q;
   logic [2:0]                         word_q;
   logic [mchan_prog_pkg::CNT_W-1:0]   tr_q;
   logic [mchan_prog_pkg::CNT_W-1:0]   batch_q;
   logic [mchan_prog_pkg::DATA_W-1:0]  tcdm_q;
   logic [mchan_prog_pkg::DATA_W-1:0]  ext_q;
   logic [mchan_prog_pkg::DATA_W-1:0]  slot_step_ext;
   logic [mchan_prog_pkg::HALF_W-1:0]  size;
   logic                               last_tr;
   logic                               last_batch;
   logic                               fire;
   logic                               xfer_end;

   assign last_tr    = tr_q == params_i.tr_per_batch - 1'b1;
   assign last_batch = batch_q == params_i.num_batches - 1'b1;
   assign fire       = seq_req_o.req && mchan_gnt_i;
   // fifth word of a transfer accepted
   assign xfer_end   = fire && word_q == 3'd4;
   assign done_o     = xfer_end && last_tr && last_batch;

   assign size          = last_batch ? params_i.last_size : params_i.max_size;
   assign slot_step_ext = {{(mchan_prog_pkg::DATA_W - mchan_prog_pkg::HALF_W){1'b0}},
                           params_i.slot_step};

   always_comb begin
      seq_req_o      = '0;
      seq_req_o.req  = busy_q && !gap_q;
      seq_req_o.wen  = 1'b0;
      seq_req_o.be   = '1;
      seq_req_o.addr = params_i.cmd_addr;
      case (word_q)
         3'd0:    seq_req_o.wdata = {params_i.cmd_hi, size};
         3'd1:    seq_req_o.wdata = tcdm_q;
         3'd2:    seq_req_o.wdata = ext_q;
         3'd3:    seq_req_o.wdata = params_i.ext_stride;
         default: seq_req_o.wdata = params_i.tcdm_stride;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         busy_q  <= 1'b0;
         gap_q   <= 1'b0;
         word_q  <= '0;
         tr_q    <= '0;
         batch_q <= '0;
      end else begin
         gap_q <= 1'b0;
         if (start_i) begin
            busy_q  <= 1'b1;
            word_q  <= '0;
            tr_q    <= '0;
            batch_q <= '0;
         end else if (xfer_end) begin
            word_q <= '0;
            if (done_o) begin
               busy_q <= 1'b0;
            end else begin
               // one idle cycle before the next command
               gap_q <= 1'b1;
            end
            if (last_tr) begin
               tr_q    <= '0;
               batch_q <= batch_q + 1'b1;
            end else begin
               tr_q <= tr_q + 1'b1;
            end
         end else if (fire) begin
            word_q <= word_q + 3'd1;
         end
      end
   end

   // tcdm steps every transfer and ext only at batch boundaries
   always_ff @(posedge clk_i) begin
      if (start_i) begin
         tcdm_q <= params_i.tcdm_base;
         ext_q  <= params_i.ext_base;
      end else if (xfer_end) begin
         tcdm_q <= tcdm_q + slot_step_ext;
         if (last_tr) begin
            ext_q <= ext_q + params_i.batch_step;
         end
      end
   end

endmodule

// ==== verilog/prog_bus_mux.sv ====
module prog_bus_mux (
   input  logic                     clk_i,
   input  logic                     rst_ni,
   input  mchan_prog_pkg::mode_e    mode_i,
   input  mchan_prog_pkg::bus_req_t core_req_i,
   input  mchan_prog_pkg::bus_req_t seq_req_i,
   input  mchan_prog_pkg::bus_rsp_t mchan_rsp_i,
   output mchan_prog_pkg::bus_req_t mchan_req_o,
   output mchan_prog_pkg::bus_rsp_t core_rsp_o
);

   logic pend_q;
   logic rvalid_q;
   logic cap_gnt;
   logic seen;

   // a request counts as seen in IDLE or CAPTURE
   assign seen    = mode_i == mchan_prog_pkg::IDLE || mode_i == mchan_prog_pkg::CAPTURE;
   assign cap_gnt = mode_i == mchan_prog_pkg::CAPTURE && pend_q;

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         pend_q   <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         pend_q   <= seen && core_req_i.req && !cap_gnt;
         rvalid_q <= cap_gnt;
      end
   end

   always_comb begin
      mchan_req_o = '0;
      core_rsp_o  = '0;
      case (mode_i)
         mchan_prog_pkg::PASS,
         mchan_prog_pkg::WAIT_VALID: begin
            mchan_req_o = core_req_i;
            core_rsp_o  = mchan_rsp_i;
         end
         mchan_prog_pkg::RUN: mchan_req_o = seq_req_i;
         mchan_prog_pkg::CAPTURE: begin
            // parameter writes answer with zero data
            core_rsp_o.gnt     = cap_gnt;
            core_rsp_o.r_valid = rvalid_q;
         end
         default: ;
      endcase
   end

endmodule

// ==== verilog/mchan_prog.sv ====
module mchan_prog (
   input  logic                     clk_i,
   input  logic                     rst_ni,
   input  mchan_prog_pkg::bus_req_t core_req_i,
   output mchan_prog_pkg::bus_rsp_t core_rsp_o,
   output mchan_prog_pkg::bus_req_t mchan_req_o,
   input  mchan_prog_pkg::bus_rsp_t mchan_rsp_i
);

   mchan_prog_pkg::mode_e        mode;
   logic [2:0]                   cap_idx;
   logic                         start;
   logic                         done;
   mchan_prog_pkg::prog_params_t params;
   mchan_prog_pkg::bus_req_t     seq_req;

   prog_req_decode u_decode (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .core_req_i  (core_req_i),
      .mchan_rsp_i (mchan_rsp_i),
      .done_i      (done),
      .mode_o      (mode),
      .cap_idx_o   (cap_idx),
      .start_o     (start)
   );

   prog_param_store u_store (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .mode_i     (mode),
      .cap_idx_i  (cap_idx),
      .core_req_i (core_req_i),
      .params_o   (params)
   );

   prog_cmd_sequencer u_seq (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .start_i     (start),
      .params_i    (params),
      .mchan_gnt_i (mchan_rsp_i.gnt),
      .seq_req_o   (seq_req),
      .done_o      (done)
   );

   prog_bus_mux u_mux (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .mode_i      (mode),
      .core_req_i  (core_req_i),
      .seq_req_i   (seq_req),
      .mchan_rsp_i (mchan_rsp_i),
      .mchan_req_o (mchan_req_o),
      .core_rsp_o  (core_rsp_o)
   );

endmodule

// ==== testbench/tb_mchan_prog.sv ====
module tb_mchan_prog;

   typedef logic [mchan_prog_pkg::DATA_W-1:0] word_t;
   typedef word_t word_q_t[$];

   // 1 + 2 + 5 + 30 + 1 controller words over all tests
   localparam int    TOTAL_WORDS = 39;
   localparam int    CYCLE_LIMIT = TOTAL_WORDS * 8 + 200;
   localparam word_t PROG_ADDR   = 32'h1a10_0000;

   logic                     clk_i;
   logic                     rst_ni    = 1'b0;
   mchan_prog_pkg::bus_req_t core_req  = '0;
   mchan_prog_pkg::bus_rsp_t core_rsp;
   mchan_prog_pkg::bus_req_t mchan_req;
   mchan_prog_pkg::bus_rsp_t mchan_rsp = '0;

   mchan_prog_pkg::bus_req_t got_q[$];
   mchan_prog_pkg::bus_req_t exp_q[$];
   int unsigned              stall    = 0;
   int                       errors   = 0;
   int                       checks   = 0;
   int                       err_mark = 0;
   int                       test_no  = 0;
   int                       gnt_cnt  = 0;
   int                       rv_cnt   = 0;
   int                       req_cnt  = 0;
   int                       cycles   = 0;

   mchan_prog UUT (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .core_req_i  (core_req),
      .core_rsp_o  (core_rsp),
      .mchan_req_o (mchan_req),
      .mchan_rsp_i (mchan_rsp)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   // read data of the controller model
   function automatic word_t rdata_of(input word_t addr);
      return addr ^ 32'h5a3c_c3a5;
   endfunction

   function automatic mchan_prog_pkg::bus_req_t make_req(input logic wen,
         input logic [mchan_prog_pkg::BE_W-1:0] be, input word_t addr, input word_t wdata);
      mchan_prog_pkg::bus_req_t r;
      r.req   = 1'b1;
      r.wen   = wen;
      r.be    = be;
      r.addr  = addr;
      r.wdata = wdata;
      return r;
   endfunction

   // expected command words for one parameter set
   function automatic word_q_t ref_cmds(input word_t prm[8]);
      word_q_t     q;
      word_t       tcdm;
      word_t       ext;
      logic [15:0] size;
      int          nb;
      int          tpb;
      nb   = int'(prm[6][31:16]);
      tpb  = int'(prm[5][31:16]);
      tcdm = prm[1];
      ext  = prm[2];
      for (int b = 0; b < nb; b++) begin
         size = (b == nb - 1) ? prm[6][15:0] : prm[0][15:0];
         for (int t = 0; t < tpb; t++) begin
            q.push_back({prm[0][31:16], size});
            q.push_back(tcdm);
            q.push_back(ext);
            q.push_back(prm[3]);
            q.push_back(prm[4]);
            tcdm = tcdm + {16'h0, prm[5][15:0]};
         end
         ext = ext + prm[7];
      end
      return q;
   endfunction

   task automatic check_val(input string name, input word_t got, input word_t exp);
      checks++;
      assert (got === exp) else begin
         $display("[FAIL] %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic report_test(input string name);
      test_no++;
      $display("test %0d %s: %0d errors", test_no, name, errors - err_mark);
      err_mark = errors;
   endtask

   // one core access started on a rising edge
   task automatic core_access(input logic wen, input logic [mchan_prog_pkg::BE_W-1:0] be,
         input word_t addr, input word_t wdata, output word_t rdata);
      core_req <= make_req(wen, be, addr, wdata);
      do @(posedge clk_i); while (!core_rsp.gnt);
      core_req.req <= 1'b0;
      do @(posedge clk_i); while (!core_rsp.r_valid);
      rdata = core_rsp.rdata;
   endtask

   task automatic load_program(input word_t prm[8]);
      word_t rd;
      for (int i = 0; i < 8; i++) begin
         core_access(1'b0, 4'hf, PROG_ADDR + 32'(i * 4), prm[i], rd);
         check_val("core_rsp_o.rdata", rd, '0);
      end
   endtask

   task automatic queue_cmds(input word_t prm[8]);
      word_q_t cmds;
      cmds = ref_cmds(prm);
      foreach (cmds[i]) begin
         exp_q.push_back(make_req(1'b0, 4'hf, PROG_ADDR, cmds[i]));
      end
   endtask

   task automatic wait_expected();
      while (exp_q.size() != 0) @(posedge clk_i);
   endtask

   // controller model stalls 0 to 3 cycles before each grant
   always @(posedge clk_i) begin
      if (!rst_ni) begin
         mchan_rsp <= '0;
         stall     <= 0;
      end else begin
         mchan_rsp.gnt     <= 1'b0;
         mchan_rsp.r_valid <= 1'b0;
         if (mchan_rsp.gnt) begin
            got_q.push_back(mchan_req);
            mchan_rsp.r_valid <= 1'b1;
            mchan_rsp.rdata   <= rdata_of(mchan_req.addr);
            stall             <= $urandom_range(3, 0);
         end else if (mchan_req.req) begin
            if (stall == 0) mchan_rsp.gnt <= 1'b1;
            else stall <= stall - 1;
         end
      end
   end

   always @(negedge clk_i) begin
      if (core_rsp.gnt) gnt_cnt++;
      if (core_rsp.r_valid) rv_cnt++;
      if (mchan_req.req) req_cnt++;
   end

   // compares granted controller requests in order
   always @(negedge clk_i) begin
      mchan_prog_pkg::bus_req_t got;
      mchan_prog_pkg::bus_req_t exp;
      while (got_q.size() > 0) begin
         got = got_q.pop_front();
         assert (exp_q.size() > 0) else begin
            $display("unexpected request reached the controller at address %h", got.addr);
            errors++;
         end
         if (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            check_val("mchan_req_o.wen", 32'(got.wen), 32'(exp.wen));
            check_val("mchan_req_o.be", 32'(got.be), 32'(exp.be));
            check_val("mchan_req_o.addr", got.addr, exp.addr);
            check_val("mchan_req_o.wdata", got.wdata, exp.wdata);
         end
      end
   end

   initial begin
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk_i);
         cycles++;
      end
      $display("timeout after %0d cycles, the DUT stopped responding", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
   end

   initial begin
      word_t prm_a[8];
      word_t prm_b[8];
      word_t rd;
      int    g0;
      int    r0;
      int    q0;
      prm_a = '{32'h0076_0040, 32'h0000_2000, 32'h8000_0000, 32'h0000_0010,
                32'h0000_0020, 32'h0001_0080, 32'h0001_0020, 32'h0000_0400};
      prm_b = '{32'h1237_0100, 32'h0000_4000, 32'h9000_0000, 32'h0000_0040,
                32'h0000_0080, 32'h0002_0100, 32'h0003_0030, 32'h0000_1000};
      void'($urandom(32'hf778_a731));
      repeat (8) @(posedge clk_i);
      rst_ni <= 1'b1;
      @(posedge clk_i);

      exp_q.push_back(make_req(1'b1, 4'hf, 32'h1000_0040, 32'h0005_0000));
      core_access(1'b1, 4'hf, 32'h1000_0040, 32'h0005_0000, rd);
      check_val("core_rsp_o.rdata", rd, rdata_of(32'h1000_0040));
      wait_expected();
      report_test("pass-through read");

      // partial byte enables keep a programming opcode from capture
      exp_q.push_back(make_req(1'b0, 4'hf, 32'h1000_0100, 32'h0003_abcd));
      exp_q.push_back(make_req(1'b0, 4'h3, 32'h1000_0104, 32'h0006_1234));
      core_access(1'b0, 4'hf, 32'h1000_0100, 32'h0003_abcd, rd);
      core_access(1'b0, 4'h3, 32'h1000_0104, 32'h0006_1234, rd);
      wait_expected();
      report_test("pass-through writes");

      queue_cmds(prm_a);
      g0 = gnt_cnt;
      r0 = rv_cnt;
      q0 = req_cnt;
      load_program(prm_a);
      check_val("core_rsp_o.gnt count", 32'(gnt_cnt - g0), 32'd8);
      check_val("core_rsp_o.r_valid count", 32'(rv_cnt - r0), 32'd8);
      check_val("mchan_req_o.req cycles", 32'(req_cnt - q0), 32'd0);
      report_test("parameter capture");

      wait_expected();
      repeat (4) @(posedge clk_i);
      report_test("single transfer replay");

      queue_cmds(prm_b);
      load_program(prm_b);
      wait_expected();
      repeat (4) @(posedge clk_i);
      report_test("three batch replay");

      exp_q.push_back(make_req(1'b1, 4'hf, 32'h1000_0080, 32'h0000_0000));
      core_access(1'b1, 4'hf, 32'h1000_0080, 32'h0000_0000, rd);
      check_val("core_rsp_o.rdata", rd, rdata_of(32'h1000_0080));
      wait_expected();
      report_test("read after replay");

      q0 = req_cnt;
      repeat (4) @(posedge clk_i);
      assert (req_cnt == q0) else begin
         $display("controller request seen after the last access had finished");
         errors++;
      end
      $display("%0d tests, %0d checks, %0d errors", test_no, checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== mchan_prog.f ====
verilog/mchan_prog_pkg.sv
verilog/prog_req_decode.sv
verilog/prog_param_store.sv
verilog/prog_cmd_sequencer.sv
verilog/prog_bus_mux.sv
verilog/mchan_prog.sv
testbench/tb_mchan_prog.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mchan_prog
FILELIST  ?= mchan_prog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^Test completed successfully$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
